//--- hdl/pktgen_defines.svh
// widths, frame limits, reset seeds and pattern constants; include wherever they are used
`ifndef PKTGEN_DEFINES_SVH
`define PKTGEN_DEFINES_SVH

// ----------------------------------------------------------------------
// bus widths
// ----------------------------------------------------------------------
`define PKTGEN_DATA_W      64          // stream width
`define PKTGEN_ADDR_W      8           // register address width, in words
`define PKTGEN_LEN_W       14          // frame length register width

// frame length limits, in bytes
`define PKTGEN_MIN_FRAME   24          // shorter frames carry no payload
`define PKTGEN_MAX_FRAME   9600        // jumbo limit
`define PKTGEN_OVERHEAD    18          // 14 header bytes + 4 fcs bytes

// payload generator
`define PKTGEN_PRBS_W      23          // one prbs23 lane
`define PKTGEN_SEED0_RST   32'h5EED0000
`define PKTGEN_SEED1_RST   32'h5EED0001
`define PKTGEN_SEED2_RST   5'h0D       // non zero so prbs runs with no seed written
`define PKTGEN_INC_FIRST   64'h0001020304050607
`define PKTGEN_INC_STEP    64'h0808080808080808

`endif

//--- hdl/pktgen_pkg.sv
// shared enums of the packet generator; modules import it inside their body
`default_nettype none

`include "pktgen_defines.svh"

package pktgen_pkg;

   // register map, word addresses
   typedef enum logic [`PKTGEN_ADDR_W-1:0] {
      ADDR_NUMPKTS       = 8'd0,
      ADDR_RANDOMPAYLOAD = 8'd2,    // 0 incrementing, 1 prbs
      ADDR_START         = 8'd3,    // self clearing
      ADDR_STOP          = 8'd4,
      ADDR_MACSA0        = 8'd5,    // sa[31:0]
      ADDR_MACSA1        = 8'd6,    // sa[47:32]
      ADDR_MACDA0        = 8'd7,
      ADDR_MACDA1        = 8'd8,
      ADDR_TXPKTCNT      = 8'd9,    // read only
      ADDR_RNDSEED0      = 8'd10,
      ADDR_RNDSEED1      = 8'd11,
      ADDR_RNDSEED2      = 8'd12,   // seed[68:64]
      ADDR_PKTLENGTH     = 8'd13
   } csr_addr_e;

   // frame sequencer states
   typedef enum logic [2:0] {
      ST_IDLE,                      // waiting for start
      ST_NEXT,                      // end of run check before each packet
      ST_HDR0,                      // da + sa[47:32]
      ST_HDR1,                      // sa[31:0] + length + seq
      ST_PAYLOAD
   } seq_state_e;

endpackage

`default_nettype wire

//--- hdl/gen_if.sv
// links the frame sequencer to the header builder and the payload source; one instance in the top
`default_nettype none

`include "pktgen_defines.svh"

interface gen_if;

   logic                      run_start;   // pulse, run begins
   logic                      new_pkt;     // pulse, next packet about to start
   logic                      hdr_beat_1;  // pick header word 1
   logic                      advance;     // pulse, payload word consumed
   logic [`PKTGEN_LEN_W-1:0]  pay_len;     // payload bytes, valid after new_pkt
   logic [`PKTGEN_DATA_W-1:0] hdr_word;
   logic [`PKTGEN_DATA_W-1:0] pay_word;    // valid after new_pkt or advance

   modport seq (output run_start, new_pkt, hdr_beat_1, advance,
                input  pay_len, hdr_word, pay_word);
   modport hdr (input  run_start, new_pkt, hdr_beat_1,
                output pay_len, hdr_word);
   modport pay (input  run_start, new_pkt, advance,
                output pay_word);

endinterface

`default_nettype wire

//--- hdl/pktgen_csr.sv
// register file of the generator: settings, start pulse, stop level and readback
`default_nettype none

`include "pktgen_defines.svh"

module pktgen_csr (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`PKTGEN_ADDR_W-1:0] address,
   input  logic                     write,
   input  logic                     read,
   input  logic [31:0]              writedata,
   output logic [31:0]              readdata,
   input  logic [31:0]              tx_pkt_count,   // from the sequencer
   output logic                     start,          // one cycle pulse
   output logic                     stop,
   output logic [31:0]              number_packet,
   output logic                     random_payload,
   output logic [`PKTGEN_LEN_W-1:0] pkt_length,
   output logic [47:0]              mac_da,
   output logic [47:0]              mac_sa,
   output logic [68:0]              prbs_seed
);
   import pktgen_pkg::*;

   logic        start_reg;   // self clearing
   logic        start_d;
   logic [31:0] mac_sa_lo, mac_da_lo;
   logic [15:0] mac_sa_hi, mac_da_hi;
   logic [31:0] seed0, seed1;
   logic [4:0]  seed2;

   // ----------------------------------------------------------------------
   // write side
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         number_packet  <= '0;
         random_payload <= 1'b0;
         start_reg      <= 1'b0;
         stop           <= 1'b0;
         pkt_length     <= '0;
         mac_sa_lo      <= '0;
         mac_sa_hi      <= '0;
         mac_da_lo      <= '0;
         mac_da_hi      <= '0;
         seed0          <= `PKTGEN_SEED0_RST;
         seed1          <= `PKTGEN_SEED1_RST;
         seed2          <= `PKTGEN_SEED2_RST;
      end else begin
         start_reg <= 1'b0;                                 // clears itself
         if (write) begin
            case (csr_addr_e'(address))
               ADDR_NUMPKTS:       number_packet  <= writedata;
               ADDR_RANDOMPAYLOAD: random_payload <= writedata[0];
               ADDR_START:         start_reg      <= writedata[0];
               ADDR_STOP:          stop           <= writedata[0];
               ADDR_MACSA0:        mac_sa_lo      <= writedata;
               ADDR_MACSA1:        mac_sa_hi      <= writedata[15:0];
               ADDR_MACDA0:        mac_da_lo      <= writedata;
               ADDR_MACDA1:        mac_da_hi      <= writedata[15:0];
               ADDR_RNDSEED0:      seed0          <= writedata;
               ADDR_RNDSEED1:      seed1          <= writedata;
               ADDR_RNDSEED2:      seed2          <= writedata[4:0];
               ADDR_PKTLENGTH:     pkt_length     <= writedata[`PKTGEN_LEN_W-1:0];
               default: ;                                   // read only or unmapped
            endcase
         end
      end
   end

   // edge detect, a held start bit still gives one pulse
   always_ff @(posedge clk or posedge reset) begin
      if (reset) start_d <= 1'b0;
      else       start_d <= start_reg;
   end

   assign start     = start_reg & ~start_d;
   assign mac_sa    = {mac_sa_hi, mac_sa_lo};
   assign mac_da    = {mac_da_hi, mac_da_lo};
   assign prbs_seed = {seed2, seed1, seed0};

   // ----------------------------------------------------------------------
   // readback, valid the cycle after read
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (read) begin
         case (csr_addr_e'(address))
            ADDR_NUMPKTS:       readdata <= number_packet;
            ADDR_RANDOMPAYLOAD: readdata <= {31'b0, random_payload};
            ADDR_START:         readdata <= {31'b0, start_reg};
            ADDR_STOP:          readdata <= {31'b0, stop};
            ADDR_MACSA0:        readdata <= mac_sa_lo;
            ADDR_MACSA1:        readdata <= {16'b0, mac_sa_hi};
            ADDR_MACDA0:        readdata <= mac_da_lo;
            ADDR_MACDA1:        readdata <= {16'b0, mac_da_hi};
            ADDR_TXPKTCNT:      readdata <= tx_pkt_count;
            ADDR_RNDSEED0:      readdata <= seed0;
            ADDR_RNDSEED1:      readdata <= seed1;
            ADDR_RNDSEED2:      readdata <= {27'b0, seed2};
            ADDR_PKTLENGTH:     readdata <= {{(32-`PKTGEN_LEN_W){1'b0}}, pkt_length};
            default:            readdata <= '0;
         endcase
      end
   end

   // a run can only be kicked off once per write
   a_start_single: assert property (@(posedge clk) disable iff (reset) start |=> !start);

endmodule

`default_nettype wire

//--- hdl/header_builder.sv
// forms the two ethernet header words and keeps payload length and sequence number per packet
`default_nettype none

`include "pktgen_defines.svh"

module header_builder (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`PKTGEN_LEN_W-1:0] pkt_length,
   input  logic [47:0]              mac_da,
   input  logic [47:0]              mac_sa,
   gen_if.hdr                       gen
);
   import pktgen_pkg::*;

   logic [`PKTGEN_LEN_W-1:0]  len_calc;
   logic [15:0]               seq_num;
   logic                      pkt_sent;     // a packet went out since run_start
   seq_state_e                beat_sel;
   logic [`PKTGEN_DATA_W-1:0] word0, word1;

   // payload length from the programmed frame length
   always_comb begin
      if (pkt_length < `PKTGEN_LEN_W'(`PKTGEN_MIN_FRAME))
         len_calc = '0;                                     // too short, header only
      else if (pkt_length > `PKTGEN_LEN_W'(`PKTGEN_MAX_FRAME))
         len_calc = `PKTGEN_LEN_W'(`PKTGEN_MAX_FRAME - `PKTGEN_OVERHEAD);
      else
         len_calc = pkt_length - `PKTGEN_LEN_W'(`PKTGEN_OVERHEAD);
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         gen.pay_len <= '0;
         seq_num     <= '0;
         pkt_sent    <= 1'b0;
      end else if (gen.run_start) begin
         seq_num  <= '0;
         pkt_sent <= 1'b0;
      end else if (gen.new_pkt) begin
         gen.pay_len <= len_calc;
         pkt_sent    <= 1'b1;
         if (pkt_sent) seq_num <= seq_num + 16'd1;         // previous frame is done
      end
   end

   assign word0 = {mac_da, mac_sa[47:32]};
   assign word1 = {mac_sa[31:0], 16'(gen.pay_len) + 16'd6, seq_num};   // length field is L + 6

   assign beat_sel = gen.hdr_beat_1 ? ST_HDR1 : ST_HDR0;

   always_comb begin
      case (beat_sel)
         ST_HDR1: gen.hdr_word = word1;
         default: gen.hdr_word = word0;
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/payload_source.sv
// payload word generator, incrementing byte pattern or three prbs23 lanes
`default_nettype none

`include "pktgen_defines.svh"

module payload_source (
   input  logic        clk,
   input  logic        reset,
   input  logic        random_payload,   // 1 selects prbs
   input  logic [68:0] prbs_seed,
   gen_if.pay          gen
);

   logic [`PKTGEN_PRBS_W-1:0] lane0, lane1, lane2;
   logic [`PKTGEN_DATA_W-1:0] inc_word;

   // ----------------------------------------------------------------------
   // prbs23, g(x) = x^23 + x^18 + 1, advanced 23 bits per word
   // ----------------------------------------------------------------------
   function automatic logic [`PKTGEN_PRBS_W-1:0] prbs_step(
      input logic [`PKTGEN_PRBS_W-1:0] lane
   );
      logic [`PKTGEN_PRBS_W-1:0] s;
      s = lane;
      for (int i = 0; i < `PKTGEN_PRBS_W; i++) begin
         s = {s[18] ^ s[0], s[`PKTGEN_PRBS_W-1:1]};       // lsb goes out first
      end
      return s;
   endfunction

   // lanes run on across packets, reloaded only at run start
   always_ff @(posedge clk) begin
      if (gen.run_start) begin
         lane0 <= prbs_seed[22:0];
         lane1 <= prbs_seed[45:23];
         lane2 <= prbs_seed[68:46];
      end else if (gen.advance) begin
         lane0 <= prbs_step(lane0);
         lane1 <= prbs_step(lane1);
         lane2 <= prbs_step(lane2);
      end
   end

   // incrementing pattern restarts every packet
   always_ff @(posedge clk) begin
      if (gen.new_pkt)
         inc_word <= `PKTGEN_INC_FIRST;
      else if (gen.advance)
         inc_word <= inc_word + `PKTGEN_INC_STEP;        // bytes step by 8
   end

   // low 64 bits of {lane2, lane1, lane0}
   assign gen.pay_word = random_payload ? {lane2[17:0], lane1, lane0} : inc_word;

   // the sequencer must never consume a word while the lanes reload
   a_no_adv_on_load: assert property (@(posedge clk) disable iff (reset)
      !(gen.advance && gen.run_start));

endmodule

`default_nettype wire

//--- hdl/frame_sequencer.sv
// run and packet fsm, merges header and payload words into the registered avalon-st output
`default_nettype none

`include "pktgen_defines.svh"

module frame_sequencer (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      start,
   input  logic                      stop,
   input  logic [31:0]               number_packet,
   output logic [31:0]               tx_pkt_count,
   gen_if.seq                        gen,
   input  logic                      tx_ready,
   output logic [`PKTGEN_DATA_W-1:0] tx_data,
   output logic                      tx_valid,
   output logic                      tx_sop,
   output logic                      tx_eop,
   output logic [2:0]                tx_empty
);
   import pktgen_pkg::*;

   seq_state_e                state, state_nxt;
   logic [`PKTGEN_LEN_W-1:0]  beats_left;   // payload beats still to load
   logic                      slot_free;    // output register free at this edge
   logic                      beat_ld;
   logic                      beat_sop, beat_eop;
   logic [2:0]                beat_empty;
   logic [`PKTGEN_DATA_W-1:0] beat_data;

   assign slot_free = ~tx_valid | tx_ready;

   // ----------------------------------------------------------------------
   // next state and next beat
   // ----------------------------------------------------------------------
   always_comb begin
      state_nxt      = state;
      gen.run_start  = 1'b0;
      gen.new_pkt    = 1'b0;
      gen.advance    = 1'b0;
      gen.hdr_beat_1 = (state == ST_HDR1);
      beat_ld        = 1'b0;
      beat_sop       = 1'b0;
      beat_eop       = 1'b0;
      beat_empty     = 3'd0;
      beat_data      = gen.hdr_word;
      case (state)
         ST_IDLE: if (start) begin
            gen.run_start = 1'b1;                       // clear count, seq, load lanes
            state_nxt     = ST_NEXT;
         end
         ST_NEXT: begin
            if (tx_pkt_count == number_packet || stop) begin
               state_nxt = ST_IDLE;                     // run over, nothing partial
            end else begin
               gen.new_pkt = 1'b1;
               state_nxt   = ST_HDR0;
            end
         end
         ST_HDR0: if (slot_free) begin
            beat_ld   = 1'b1;
            beat_sop  = 1'b1;
            state_nxt = ST_HDR1;
         end
         ST_HDR1: if (slot_free) begin
            beat_ld   = 1'b1;
            beat_eop  = (gen.pay_len == '0);            // header only frame
            state_nxt = beat_eop ? ST_NEXT : ST_PAYLOAD;
         end
         ST_PAYLOAD: if (slot_free) begin
            beat_ld     = 1'b1;
            beat_data   = gen.pay_word;
            gen.advance = 1'b1;
            if (beats_left == `PKTGEN_LEN_W'(1)) begin
               beat_eop   = 1'b1;
               beat_empty = 3'd0 - gen.pay_len[2:0];    // (8 - L mod 8) mod 8
               state_nxt  = ST_NEXT;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state        <= ST_IDLE;
         beats_left   <= '0;
         tx_valid     <= 1'b0;
         tx_sop       <= 1'b0;
         tx_eop       <= 1'b0;
         tx_empty     <= 3'd0;
         tx_pkt_count <= '0;
      end else begin
         state <= state_nxt;
         if (state == ST_HDR1)
            beats_left <= (gen.pay_len + `PKTGEN_LEN_W'(7)) >> 3;   // ceil(L/8)
         else if (gen.advance)
            beats_left <= beats_left - `PKTGEN_LEN_W'(1);
         if (slot_free) begin                           // else hold for the sink
            tx_valid <= beat_ld;
            tx_sop   <= beat_sop;
            tx_eop   <= beat_eop;
            tx_empty <= beat_empty;
         end
         if (gen.run_start)
            tx_pkt_count <= '0;
         else if (tx_valid && tx_ready && tx_sop)
            tx_pkt_count <= tx_pkt_count + 32'd1;      // counted on beat 0
      end
   end

   always_ff @(posedge clk) begin
      if (slot_free && beat_ld) tx_data <= beat_data;
   end

   // avalon-st rule, a stalled beat must not change
   a_tx_hold: assert property (@(posedge clk) disable iff (reset)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_sop)
                                && $stable(tx_eop) && $stable(tx_empty));

endmodule

`default_nettype wire

//--- hdl/pktgen_top.sv
// top of the ethernet test frame generator, register port in and avalon-st stream out
`default_nettype none

`include "pktgen_defines.svh"

module pktgen_top (
   input  logic                      clk,
   input  logic                      reset,
   input  logic [`PKTGEN_ADDR_W-1:0] address,
   input  logic                      write,
   input  logic                      read,
   input  logic [31:0]               writedata,
   output logic [31:0]               readdata,
   input  logic                      tx_ready,
   output logic [`PKTGEN_DATA_W-1:0] tx_data,
   output logic                      tx_valid,
   output logic                      tx_sop,
   output logic                      tx_eop,
   output logic [2:0]                tx_empty
);

   logic                     start, stop, random_payload;
   logic [31:0]              number_packet, tx_pkt_count;
   logic [`PKTGEN_LEN_W-1:0] pkt_length;
   logic [47:0]              mac_da, mac_sa;
   logic [68:0]              prbs_seed;

   gen_if gen_bus ();

   pktgen_csr i_pktgen_csr (
      .clk, .reset, .address, .write, .read, .writedata, .readdata,
      .tx_pkt_count, .start, .stop, .number_packet, .random_payload,
      .pkt_length, .mac_da, .mac_sa, .prbs_seed
   );

   header_builder i_header_builder (
      .clk, .reset, .pkt_length, .mac_da, .mac_sa,
      .gen (gen_bus.hdr)
   );

   payload_source i_payload_source (
      .clk, .reset, .random_payload, .prbs_seed,
      .gen (gen_bus.pay)
   );

   frame_sequencer i_frame_sequencer (
      .clk, .reset, .start, .stop, .number_packet, .tx_pkt_count,
      .gen (gen_bus.seq),
      .tx_ready, .tx_data, .tx_valid, .tx_sop, .tx_eop, .tx_empty
   );

endmodule

`default_nettype wire

//--- test/tb_pktgen.sv
// random-stimulus testbench for pktgen_top; rebuilds every frame in a model and checks each beat
`default_nettype none

`include "pktgen_defines.svh"

module tb_pktgen;
   timeunit 1ns;
   timeprecision 1ps;
   import pktgen_pkg::*;

   localparam int LIMIT = 100000;              // cycles allowed per wait

   logic                      clk, reset;
   logic [`PKTGEN_ADDR_W-1:0] address;
   logic                      write, read;
   logic [31:0]               writedata, readdata;
   logic                      tx_ready;
   logic [`PKTGEN_DATA_W-1:0] tx_data;
   logic                      tx_valid, tx_sop, tx_eop;
   logic [2:0]                tx_empty;

   logic [31:0] rng, rdy_rng;                  // stimulus and ready streams
   bit          ready_random;                  // 0 keeps tx_ready high
   int          value_errs, other_errs;
   int          sop_count;                     // frames seen on the stream
   logic [63:0] cap_data[$], exp_data[$];
   logic [4:0]  cap_ctl[$], exp_ctl[$];        // {sop, eop, empty}
   logic        prev_stall;
   logic [63:0] prev_data;
   logic [5:0]  prev_ctl;
   // settings of the current run
   logic [47:0] da, sa;
   logic [68:0] seed;
   logic [`PKTGEN_LEN_W-1:0] plen;
   bit          prbs_on;

   pktgen_top i_pktgen_top (
      .clk, .reset, .address, .write, .read, .writedata, .readdata,
      .tx_ready, .tx_data, .tx_valid, .tx_sop, .tx_eop, .tx_empty
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   // 23 steps at once; bit i of the next state is b[n+23+i] = b[n+18+i] ^ b[n+i]
   function automatic logic [22:0] prbs_jump(input logic [22:0] s);
      logic [22:0] t;
      for (int i = 0; i < 5; i++) t[i] = s[i] ^ s[i+18];
      for (int i = 5; i < 23; i++) t[i] = s[i] ^ t[i-5];   // tap already in the new word
      return t;
   endfunction

   task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         value_errs++;
         $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic end_test();
      $display("checks done: %0d value errors, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   endtask

   task automatic fail_now(input string why);
      other_errs++;
      $display("%s", why);
      end_test();
   endtask

   task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
      @(posedge clk);
      address   <= a;
      writedata <= d;
      write     <= 1'b1;
      @(posedge clk);                          // register takes it here
      write     <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] a, output logic [31:0] d);
      @(posedge clk);
      address <= a;
      read    <= 1'b1;
      @(posedge clk);
      read    <= 1'b0;
      @(posedge clk);
      d = readdata;                            // loaded one edge earlier
   endtask

   // waits for 40 cycles in a row without tx_valid
   task automatic wait_quiet();
      int quiet, n;
      quiet = 0;
      n     = 0;
      while (quiet < 40 && n < LIMIT) begin
         @(posedge clk);
         quiet = tx_valid ? 0 : quiet + 1;
         n++;
      end
      if (quiet < 40) fail_now("timeout: the stream never went idle");
   endtask

   // ----------------------------------------------------------------------
   // stream monitor, samples the values the DUT saw at this edge
   // ----------------------------------------------------------------------
   always @(posedge clk) begin
      rdy_rng  <= xorshift(rdy_rng);
      tx_ready <= !ready_random || (rdy_rng % 32'd10 >= 32'd3);   // low about 30%
      if (!reset) begin
         if (prev_stall) begin                 // stalled beat must hold
            compare(tx_data, prev_data, "tx_data changed under back-pressure");
            compare(64'({tx_valid, tx_sop, tx_eop, tx_empty}), 64'(prev_ctl),
                    "tx controls changed under back-pressure");
         end
         if (tx_valid && tx_ready) begin
            cap_data.push_back(tx_data);
            cap_ctl.push_back({tx_sop, tx_eop, tx_empty});
            if (tx_sop) sop_count <= sop_count + 1;
         end
         prev_stall <= tx_valid && !tx_ready;
         prev_data  <= tx_data;
         prev_ctl   <= {tx_valid, tx_sop, tx_eop, tx_empty};
      end
   end

   // ----------------------------------------------------------------------
   // frame model
   // ----------------------------------------------------------------------
   task automatic build_expected(input int n);
      int          p, len, nbeats;
      logic [22:0] l0, l1, l2;
      logic [63:0] inc;
      exp_data.delete();
      exp_ctl.delete();
      p = 32'(plen);
      if (p < `PKTGEN_MIN_FRAME) len = 0;
      else if (p > `PKTGEN_MAX_FRAME) len = `PKTGEN_MAX_FRAME - `PKTGEN_OVERHEAD;
      else len = p - `PKTGEN_OVERHEAD;
      nbeats = (len + 7) / 8;
      l0 = seed[22:0];                         // lanes run on across the whole run
      l1 = seed[45:23];
      l2 = seed[68:46];
      for (int k = 0; k < n; k++) begin
         exp_data.push_back({da, sa[47:32]});
         exp_ctl.push_back(5'b10000);
         exp_data.push_back({sa[31:0], 16'(len + 6), 16'(k)});
         exp_ctl.push_back({1'b0, len == 0, 3'd0});
         inc = `PKTGEN_INC_FIRST;
         for (int b = 0; b < nbeats; b++) begin
            exp_data.push_back(prbs_on ? {l2[17:0], l1, l0} : inc);
            exp_ctl.push_back({1'b0, b == nbeats - 1,
                               (b == nbeats - 1) ? 3'((8 - len % 8) % 8) : 3'd0});
            inc = inc + `PKTGEN_INC_STEP;
            l0 = prbs_jump(l0);
            l1 = prbs_jump(l1);
            l2 = prbs_jump(l2);
         end
      end
   endtask

   task automatic pick_settings(input bit prbs);
      logic [31:0] r;
      r = next_rand();
      da = {r[15:0], next_rand()};
      r = next_rand();
      sa = {r[15:0], next_rand()};
      seed[31:0]  = next_rand();
      seed[63:32] = next_rand();
      r = next_rand();
      seed[68:64] = r[4:0];
      prbs_on = prbs;
      r = next_rand();
      case (r[2:0])
         3'd0:    plen = 14'((r >> 3) % 32'd24);            // header only
         3'd1:    plen = 14'(32'd9601 + (r >> 3) % 32'd6783); // clipped to max
         3'd2:    plen = 14'(32'd24 + (r >> 3) % 32'd9577);
         default: plen = 14'(32'd24 + (r >> 3) % 32'd300);
      endcase
   endtask

   // one run, stop_early raises stop once two frames have begun
   task automatic run_frames(input int num, input bit prbs, input bit stop_early);
      int          base, target, n, waited;
      logic [31:0] v;
      pick_settings(prbs);
      write_reg(ADDR_NUMPKTS, num);
      write_reg(ADDR_RANDOMPAYLOAD, {31'b0, prbs});
      write_reg(ADDR_STOP, 32'd0);
      write_reg(ADDR_PKTLENGTH, 32'(plen));
      write_reg(ADDR_MACDA0, da[31:0]);
      write_reg(ADDR_MACDA1, {16'b0, da[47:32]});
      write_reg(ADDR_MACSA0, sa[31:0]);
      write_reg(ADDR_MACSA1, {16'b0, sa[47:32]});
      write_reg(ADDR_RNDSEED0, seed[31:0]);
      write_reg(ADDR_RNDSEED1, seed[63:32]);
      write_reg(ADDR_RNDSEED2, {27'b0, seed[68:64]});
      cap_data.delete();
      cap_ctl.delete();
      base = sop_count;
      write_reg(ADDR_START, 32'd1);
      target = stop_early ? 2 : num;
      waited = 0;
      while (sop_count - base < target && waited < LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (sop_count - base < target) fail_now("timeout: expected frames never started");
      if (stop_early) write_reg(ADDR_STOP, 32'd1);
      wait_quiet();
      n = sop_count - base;
      if (stop_early) compare(64'(n < num), 64'd1, "stop did not end the run early");
      else compare(64'(n), 64'(num), "frames sent");
      build_expected(n);                       // a cut frame would show as a length error
      compare(64'(cap_data.size()), 64'(exp_data.size()), "beat count");
      for (int i = 0; i < exp_data.size() && i < cap_data.size(); i++) begin
         compare(cap_data[i], exp_data[i], $sformatf("beat %0d data", i));
         compare(64'(cap_ctl[i]), 64'(exp_ctl[i]), $sformatf("beat %0d sop/eop/empty", i));
      end
      read_reg(ADDR_TXPKTCNT, v);
      compare(64'(v), 64'(n), "tx packet counter");
   endtask

   task automatic check_registers();
      logic [7:0]  addrs[11];
      logic [31:0] masks[11];
      logic [31:0] vals[11];
      logic [31:0] v;
      addrs = '{ADDR_NUMPKTS, ADDR_RANDOMPAYLOAD, ADDR_STOP, ADDR_MACSA0, ADDR_MACSA1,
                ADDR_MACDA0, ADDR_MACDA1, ADDR_RNDSEED0, ADDR_RNDSEED1, ADDR_RNDSEED2,
                ADDR_PKTLENGTH};
      masks = '{32'hFFFFFFFF, 32'h1, 32'h1, 32'hFFFFFFFF, 32'hFFFF, 32'hFFFFFFFF,
                32'hFFFF, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h1F, 32'h3FFF};
      compare(64'(readdata), 64'd0, "readdata after reset");
      compare(64'({tx_valid, tx_sop, tx_eop}), 64'd0, "stream flags after reset");
      read_reg(ADDR_RNDSEED0, v);
      compare(64'(v), 64'(`PKTGEN_SEED0_RST), "seed0 reset value");
      read_reg(ADDR_RNDSEED1, v);
      compare(64'(v), 64'(`PKTGEN_SEED1_RST), "seed1 reset value");
      read_reg(ADDR_RNDSEED2, v);
      compare(64'(v), 64'(`PKTGEN_SEED2_RST), "seed2 reset value");
      for (int i = 0; i < 11; i++) begin
         vals[i] = next_rand();
         write_reg(addrs[i], vals[i]);
      end
      for (int i = 0; i < 11; i++) begin
         read_reg(addrs[i], v);
         compare(64'(v), 64'(vals[i] & masks[i]), $sformatf("readback of address %0d", addrs[i]));
      end
      write_reg(8'd1, 32'hFFFFFFFF);           // holes ignore writes
      read_reg(8'd1, v);
      compare(64'(v), 64'd0, "unmapped address 1");
      read_reg(8'd200, v);
      compare(64'(v), 64'd0, "unmapped address 200");
      write_reg(ADDR_STOP, 32'd0);
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin
      rng          = 32'h52eb;
      rdy_rng      = 32'h52eb ^ 32'h9E3779B9;
      reset        = 1'b1;
      address      = '0;
      write        = 1'b0;
      read         = 1'b0;
      writedata    = '0;
      tx_ready     = 1'b1;
      ready_random = 1'b0;
      value_errs   = 0;
      other_errs   = 0;
      sop_count    = 0;
      prev_stall   = 1'b0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      check_registers();
      run_frames(3, 1'b0, 1'b0);               // steady ready first
      ready_random <= 1'b1;
      for (int i = 0; i < 6; i++) run_frames(1 + next_rand() % 4, 1'b0, 1'b0);
      for (int i = 0; i < 6; i++) run_frames(2 + next_rand() % 4, 1'b1, 1'b0);
      run_frames(0, 1'b0, 1'b0);               // empty run
      run_frames(40, 1'b1, 1'b1);              // cut short by stop
      end_test();
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/pktgen_pkg.sv
hdl/gen_if.sv
hdl/pktgen_csr.sv
hdl/header_builder.sv
hdl/payload_source.sv
hdl/frame_sequencer.sv
hdl/pktgen_top.sv
test/tb_pktgen.sv

//--- Makefile
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f vlog.f --top-module tb_pktgen -o sim_pktgen
	./obj_dir/sim_pktgen | tee /dev/stderr | grep -x '>>> PASS' > /dev/null

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f vlog.f --top-module pktgen_top

clean:
	rm -rf obj_dir
